//--- filelist.f
+incdir+verif
source/acc_pkg.sv
source/mac_dot.sv
source/core_acc.sv
source/result_arbiter.sv
source/result_buffer.sv
source/apb_regs.sv
source/acc_top.sv
verif/acc_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0 -Wno-fatal
TOP       = acc_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(wildcard source/*.sv) verif/acc_tb.sv verif/acc_tb_tasks.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/acc_tb_tasks.svh
// Testbench bus and lane tasks
`ifndef ACC_TB_TASKS_SVH
`define ACC_TB_TASKS_SVH

// LCG step, top byte as the sample
function automatic logic [7:0] next_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
endfunction

// One APB transfer with setup and access phases
task automatic apb_xfer(input logic wr, input logic [APB_ADDR_WIDTH-1:0] addr,
                        input logic [APB_DATA_WIDTH-1:0] wdata,
                        output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Sample just after the drive edge, well before the next rising edge
    #1;
    n = 0;
    while (!pready && n < APB_WAIT_MAX) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!pready) begin
        $display("APB access to address %h never completed, pready stayed low", addr);
        end_run(1'b0);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

// Feed groups of vectors to the masked lanes and build the expected sums
task automatic drive_lanes(input int acc_num, input logic [LANE_NUM-1:0] mask,
                           input int groups, input logic gap);
    logic signed [IDATA_WIDTH-1:0] a;
    logic signed [IDATA_WIDTH-1:0] w;
    int total [LANE_NUM];
    for (int g = 0; g < groups; g++) begin
        total = '{0, 0};
        for (int k = 0; k < acc_num; k++) begin
            @(negedge clk);
            for (int l = 0; l < LANE_NUM; l++) begin
                for (int m = 0; m < MAC_MULT_NUM; m++) begin
                    a = next_byte();
                    w = next_byte();
                    act[(l*MAC_MULT_NUM+m)*IDATA_WIDTH +: IDATA_WIDTH] = a;
                    wgt[(l*MAC_MULT_NUM+m)*IDATA_WIDTH +: IDATA_WIDTH] = w;
                    total[l] += int'(a) * int'(w);
                end
            end
            in_valid = mask;
        end
        for (int l = 0; l < LANE_NUM; l++) begin
            exp_res[l][g] = total[l];
        end
        // Idle cycle between groups
        if (gap) begin
            @(negedge clk);
            in_valid = '0;
        end
    end
    @(negedge clk);
    in_valid = '0;
endtask

`endif

//--- verif/acc_tb.sv
// Accumulation subsystem testbench
`timescale 1ns/10ps

module acc_tb;
    import acc_pkg::*;

    typedef struct packed {
        int                  acc_num;
        logic [LANE_NUM-1:0] mask;
        int                  groups;
        logic                gap;
        logic [LANE_NUM-1:0] ovf;
    } row_t;

    localparam int APB_WAIT_MAX = 20;
    localparam int SETTLE_MAX   = 30;
    localparam int ROW_NUM      = 5;
    // Count, lane mask, groups, gap, expected overflow
    localparam row_t ROWS [ROW_NUM] = '{
        '{4, 2'b01, 3,  1'b1, 2'b00},
        '{3, 2'b11, 4,  1'b1, 2'b00},
        '{5, 2'b11, 3,  1'b0, 2'b00},
        '{3, 2'b10, 10, 1'b0, 2'b10},
        '{3, 2'b10, 2,  1'b1, 2'b00}
    };

    logic                               clk;
    logic                               rstn;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [APB_ADDR_WIDTH-1:0]          paddr;
    logic [APB_DATA_WIDTH-1:0]          pwdata;
    logic [APB_DATA_WIDTH-1:0]          prdata;
    logic                               pready;
    logic                               pslverr;
    logic [LANE_NUM*LANE_VEC_WIDTH-1:0] act;
    logic [LANE_NUM*LANE_VEC_WIDTH-1:0] wgt;
    logic [LANE_NUM-1:0]                in_valid;

    logic [31:0] lcg_state = 32'd62;
    int          exp_res [LANE_NUM][16];
    int          test_num  = 0;
    int          test_errs = 0;
    int          pass_cnt  = 0;
    int          fail_cnt  = 0;

    acc_top uut (
        .clk(clk), .rstn(rstn), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .act(act), .wgt(wgt), .in_valid(in_valid)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    task automatic end_run(input logic ok);
        if (ok) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    `include "acc_tb_tasks.svh"

    task automatic finish_test(input string name);
        test_num++;
        if (test_errs == 0) begin
            pass_cnt++;
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: %0d errors", test_num, name, test_errs);
        end
        test_errs = 0;
    endtask

    // Poll STATUS until the pending results have landed
    task automatic wait_status(input logic [APB_DATA_WIDTH-1:0] exp);
        logic [APB_DATA_WIDTH-1:0] st;
        logic                      err;
        int                        n;
        n = 0;
        apb_xfer(1'b0, REG_STATUS, '0, st, err);
        while (st !== exp && n < SETTLE_MAX) begin
            apb_xfer(1'b0, REG_STATUS, '0, st, err);
            n++;
        end
        if (st !== exp) begin
            $display("STATUS stuck at %h while waiting for %h", st, exp);
            end_run(1'b0);
        end
    endtask

    initial begin
        logic [APB_DATA_WIDTH-1:0] rd;
        logic                      err;
        logic [APB_DATA_WIDTH-1:0] exp_st;
        int                        cnt;
        clk      = 1'b0;
        rstn     = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        act      = '0;
        wgt      = '0;
        in_valid = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // ====================================================================
        // Register access
        // ====================================================================
        apb_xfer(1'b0, REG_ACC_NUM, '0, rd, err);
        if (rd !== 32'd1) begin
            $display("Error at %0t: ACC_NUM after reset is %h, expected 1", $time, rd);
            test_errs++;
        end
        apb_xfer(1'b0, REG_STATUS, '0, rd, err);
        if (rd !== 32'd0 || err !== 1'b0) begin
            $display("Error at %0t: STATUS after reset is %h err %b", $time, rd, err);
            test_errs++;
        end
        apb_xfer(1'b1, REG_ACC_NUM, 32'h5a, rd, err);
        apb_xfer(1'b0, REG_ACC_NUM, '0, rd, err);
        if (rd !== 32'h5a || err !== 1'b0) begin
            $display("Error at %0t: ACC_NUM read back %h err %b", $time, rd, err);
            test_errs++;
        end
        finish_test("register access");

        // ====================================================================
        // Table rows, each starting from a clear
        // ====================================================================
        for (int r = 0; r < ROW_NUM; r++) begin
            apb_xfer(1'b1, REG_CTRL, 32'd1, rd, err);
            apb_xfer(1'b0, REG_STATUS, '0, rd, err);
            if (rd !== 32'd0) begin
                $display("Error at %0t: STATUS after clear is %h", $time, rd);
                test_errs++;
            end
            apb_xfer(1'b1, REG_ACC_NUM, 32'(ROWS[r].acc_num), rd, err);
            drive_lanes(ROWS[r].acc_num, ROWS[r].mask, ROWS[r].groups, ROWS[r].gap);
            // Counts saturate at the lane depth
            cnt    = (ROWS[r].groups > LANE_DEPTH) ? LANE_DEPTH : ROWS[r].groups;
            exp_st = '0;
            for (int l = 0; l < LANE_NUM; l++) begin
                if (ROWS[r].mask[l]) begin
                    exp_st[8*l +: 8] = 8'(cnt);
                end
                exp_st[16+l] = ROWS[r].ovf[l];
            end
            wait_status(exp_st);
            // Each lane's words from its region base
            for (int l = 0; l < LANE_NUM; l++) begin
                for (int i = 0; i < cnt; i++) begin
                    if (ROWS[r].mask[l]) begin
                        apb_xfer(1'b0, REG_RESULT_BASE + 8'(4 * (l * LANE_DEPTH + i)),
                                 '0, rd, err);
                        if (rd !== 32'(exp_res[l][i]) || err !== 1'b0) begin
                            $display("Error at %0t: lane %0d word %0d is %h err %b, expected %h",
                                     $time, l, i, rd, err, 32'(exp_res[l][i]));
                            test_errs++;
                        end
                    end
                end
            end
            finish_test($sformatf("table row %0d", r));
        end

        // ====================================================================
        // Error responses
        // ====================================================================
        apb_xfer(1'b1, REG_RESULT_BASE, 32'h1234, rd, err);
        if (err !== 1'b1) begin
            $display("Error at %0t: write to result window gave no pslverr", $time);
            test_errs++;
        end
        apb_xfer(1'b0, 8'h20, '0, rd, err);
        if (err !== 1'b1) begin
            $display("Error at %0t: unmapped read gave no pslverr", $time);
            test_errs++;
        end
        finish_test("error responses");

        $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        end_run(fail_cnt == 0);
    end

endmodule

//--- source/acc_top.sv
// Accumulation subsystem top level
`timescale 1ns/10ps

module acc_top (
    input  logic                                                 clk,
    input  logic                                                 rstn,
    input  logic                                                 psel,
    input  logic                                                 penable,
    input  logic                                                 pwrite,
    input  logic [acc_pkg::APB_ADDR_WIDTH-1:0]                   paddr,
    input  logic [acc_pkg::APB_DATA_WIDTH-1:0]                   pwdata,
    output logic [acc_pkg::APB_DATA_WIDTH-1:0]                   prdata,
    output logic                                                 pready,
    output logic                                                 pslverr,
    input  logic [acc_pkg::LANE_NUM*acc_pkg::LANE_VEC_WIDTH-1:0] act,
    input  logic [acc_pkg::LANE_NUM*acc_pkg::LANE_VEC_WIDTH-1:0] wgt,
    input  logic [acc_pkg::LANE_NUM-1:0]                         in_valid
);
    import acc_pkg::*;

    logic signed [PSUM_WIDTH-1:0]   psum [LANE_NUM];
    logic [LANE_NUM-1:0]            psum_valid;
    logic [LANE_NUM*ODATA_WIDTH-1:0] odata;
    logic [LANE_NUM-1:0]            odata_valid;
    logic [ACC_NUM_WIDTH-1:0]       cfg_acc_num;
    logic                           clr;
    logic                           rd_req;
    logic                           rd_done;
    logic [RES_ADDR_WIDTH-1:0]      rd_addr;
    logic [LANE_NUM*CNT_WIDTH-1:0]  wr_count;
    logic [LANE_NUM-1:0]            ovf;
    logic                           mem_en;
    logic                           mem_we;
    logic [RES_ADDR_WIDTH-1:0]      mem_addr;
    logic [ODATA_WIDTH-1:0]         mem_wdata;
    logic [ODATA_WIDTH-1:0]         mem_rdata;

    // Compute lanes
    for (genvar g = 0; g < LANE_NUM; g++) begin : g_lane
        mac_dot u_mac (
            .clk(clk), .rstn(rstn),
            .act(act[g*LANE_VEC_WIDTH +: LANE_VEC_WIDTH]),
            .wgt(wgt[g*LANE_VEC_WIDTH +: LANE_VEC_WIDTH]),
            .in_valid(in_valid[g]),
            .psum(psum[g]), .psum_valid(psum_valid[g])
        );
        core_acc u_acc (
            .clk(clk), .rstn(rstn), .cfg_acc_num(cfg_acc_num),
            .psum(psum[g]), .psum_valid(psum_valid[g]),
            .odata(odata[g*ODATA_WIDTH +: ODATA_WIDTH]), .odata_valid(odata_valid[g])
        );
    end

    result_arbiter u_arb (
        .clk(clk), .rstn(rstn), .odata(odata), .odata_valid(odata_valid),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_done(rd_done), .clr(clr),
        .wr_count(wr_count), .ovf(ovf), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    result_buffer u_buf (
        .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    apb_regs u_regs (
        .clk(clk), .rstn(rstn), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .cfg_acc_num(cfg_acc_num), .clr(clr), .rd_req(rd_req),
        .rd_addr(rd_addr), .rd_done(rd_done), .mem_rdata(mem_rdata),
        .wr_count(wr_count), .ovf(ovf)
    );

endmodule

//--- source/apb_regs.sv
// APB configuration and status registers
`timescale 1ns/10ps

module apb_regs (
    input  logic                                            clk,
    input  logic                                            rstn,
    input  logic                                            psel,
    input  logic                                            penable,
    input  logic                                            pwrite,
    input  logic [acc_pkg::APB_ADDR_WIDTH-1:0]              paddr,
    input  logic [acc_pkg::APB_DATA_WIDTH-1:0]              pwdata,
    output logic [acc_pkg::APB_DATA_WIDTH-1:0]              prdata,
    output logic                                            pready,
    output logic                                            pslverr,
    output logic [acc_pkg::ACC_NUM_WIDTH-1:0]               cfg_acc_num,
    output logic                                            clr,
    output logic                                            rd_req,
    output logic [acc_pkg::RES_ADDR_WIDTH-1:0]              rd_addr,
    input  logic                                            rd_done,
    input  logic [acc_pkg::ODATA_WIDTH-1:0]                 mem_rdata,
    input  logic [acc_pkg::LANE_NUM*acc_pkg::CNT_WIDTH-1:0] wr_count,
    input  logic [acc_pkg::LANE_NUM-1:0]                    ovf
);
    import acc_pkg::*;

    logic                      setup;
    logic                      access;
    logic                      ctrl_hit;
    logic                      accn_hit;
    logic                      stat_hit;
    logic                      win_hit;
    logic                      win_rd;
    logic [APB_DATA_WIDTH-1:0] status;

    // ========================================================================
    // Decode
    // ========================================================================
    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign ctrl_hit = paddr == REG_CTRL;
    assign accn_hit = paddr == REG_ACC_NUM;
    assign stat_hit = paddr == REG_STATUS;
    assign win_hit  = (paddr >= REG_RESULT_BASE)
                   && (paddr < REG_RESULT_BASE + APB_ADDR_WIDTH'(4 * RES_DEPTH));
    assign win_rd   = win_hit && !pwrite;

    // Window reads wait for the memory, all else has no wait state
    assign pready  = access && (!win_rd || rd_done);
    // Unmapped address, or write to a read-only location
    assign pslverr = access
                  && (!(ctrl_hit || accn_hit || stat_hit || win_hit)
                  || (pwrite && (win_hit || stat_hit)));

    // Counts in bytes 0 and 1, overflow from bit 16
    always_comb begin
        status = '0;
        for (int i = 0; i < LANE_NUM; i++) begin
            status[8*i +: CNT_WIDTH] = wr_count[i*CNT_WIDTH +: CNT_WIDTH];
            status[16+i]             = ovf[i];
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (accn_hit) begin
            prdata = APB_DATA_WIDTH'(cfg_acc_num);
        end else if (stat_hit) begin
            prdata = status;
        end else if (win_hit) begin
            prdata = {{(APB_DATA_WIDTH-ODATA_WIDTH){mem_rdata[ODATA_WIDTH-1]}}, mem_rdata};
        end
    end

    // ========================================================================
    // Registers
    // ========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg_acc_num <= ACC_NUM_WIDTH'(1);
            clr         <= 1'b0;
            rd_req      <= 1'b0;
        end else begin
            // One-cycle clear pulse from CTRL bit 0
            clr <= access && pwrite && ctrl_hit && pwdata[0];
            if (access && pwrite && accn_hit) begin
                cfg_acc_num <= pwdata[ACC_NUM_WIDTH-1:0];
            end
            // Raised in setup, held until the data returns
            if (rd_done) begin
                rd_req <= 1'b0;
            end else if (setup && win_rd) begin
                rd_req <= 1'b1;
            end
        end
    end

    // Word index within the window
    always_ff @(posedge clk) begin
        if (setup && win_rd) begin
            rd_addr <= paddr[RES_ADDR_WIDTH+1:2];
        end
    end

endmodule

//--- source/result_buffer.sv
// Single-port result memory
`timescale 1ns/10ps

module result_buffer (
    input  logic                               clk,
    input  logic                               mem_en,
    input  logic                               mem_we,
    input  logic [acc_pkg::RES_ADDR_WIDTH-1:0] mem_addr,
    input  logic [acc_pkg::ODATA_WIDTH-1:0]    mem_wdata,
    output logic [acc_pkg::ODATA_WIDTH-1:0]    mem_rdata
);
    import acc_pkg::*;

    logic [ODATA_WIDTH-1:0] mem [RES_DEPTH];

    // Registered read, data one cycle after the grant
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule

//--- source/result_arbiter.sv
// Result memory arbiter
`timescale 1ns/10ps

module result_arbiter (
    input  logic                                              clk,
    input  logic                                              rstn,
    input  logic [acc_pkg::LANE_NUM*acc_pkg::ODATA_WIDTH-1:0] odata,
    input  logic [acc_pkg::LANE_NUM-1:0]                      odata_valid,
    input  logic                                              rd_req,
    input  logic [acc_pkg::RES_ADDR_WIDTH-1:0]                rd_addr,
    output logic                                              rd_done,
    input  logic                                              clr,
    output logic [acc_pkg::LANE_NUM*acc_pkg::CNT_WIDTH-1:0]   wr_count,
    output logic [acc_pkg::LANE_NUM-1:0]                      ovf,
    output logic                                              mem_en,
    output logic                                              mem_we,
    output logic [acc_pkg::RES_ADDR_WIDTH-1:0]                mem_addr,
    output logic [acc_pkg::ODATA_WIDTH-1:0]                   mem_wdata
);
    import acc_pkg::*;

    logic [ODATA_WIDTH-1:0]   pend_data [LANE_NUM];
    logic [LANE_NUM-1:0]      pend_vld;
    logic [LANE_NUM-1:0]      full;
    logic [REQ_NUM-1:0]       req;
    logic [REQ_NUM-1:0]       gnt;
    logic [REQ_PTR_WIDTH-1:0] gnt_idx;
    logic [REQ_PTR_WIDTH-1:0] rr_ptr;

    // ========================================================================
    // Round-robin grant
    // ========================================================================
    // Top request bit is the APB read, masked while its data returns
    assign req = {rd_req && !rd_done, pend_vld};

    // Walk down from the far end so the slot at rr_ptr wins
    always_comb begin
        int idx;
        gnt     = '0;
        gnt_idx = '0;
        for (int k = REQ_NUM - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % REQ_NUM;
            if (req[idx]) begin
                gnt      = '0;
                gnt[idx] = 1'b1;
                gnt_idx  = REQ_PTR_WIDTH'(idx);
            end
        end
    end

    // Memory port, write happens in the grant cycle
    always_comb begin
        mem_en    = gnt[REQ_NUM-1];
        mem_we    = 1'b0;
        mem_addr  = rd_addr;
        mem_wdata = '0;
        for (int i = 0; i < LANE_NUM; i++) begin
            full[i] = wr_count[i*CNT_WIDTH +: CNT_WIDTH] == CNT_WIDTH'(LANE_DEPTH);
            if (gnt[i] && !full[i]) begin
                mem_en    = 1'b1;
                mem_we    = 1'b1;
                // Lane region base plus count
                mem_addr  = RES_ADDR_WIDTH'(i * LANE_DEPTH)
                          + RES_ADDR_WIDTH'(wr_count[i*CNT_WIDTH +: CNT_WIDTH]);
                mem_wdata = pend_data[i];
            end
        end
    end

    // ========================================================================
    // Pending flags, pointers and counts
    // ========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_vld <= '0;
            wr_count <= '0;
            ovf      <= '0;
            rr_ptr   <= '0;
            rd_done  <= 1'b0;
        end else begin
            // Read data valid one cycle after its grant
            rd_done <= gnt[REQ_NUM-1];
            if (|gnt) begin
                rr_ptr <= (gnt_idx == REQ_PTR_WIDTH'(REQ_NUM - 1)) ? '0 : gnt_idx + 1'b1;
            end
            for (int i = 0; i < LANE_NUM; i++) begin
                if (odata_valid[i]) begin
                    pend_vld[i] <= 1'b1;
                end else if (gnt[i]) begin
                    pend_vld[i] <= 1'b0;
                end
                if (clr) begin
                    wr_count[i*CNT_WIDTH +: CNT_WIDTH] <= '0;
                    ovf[i]                             <= 1'b0;
                end else if (gnt[i]) begin
                    // Full lane drops the result
                    if (full[i]) begin
                        ovf[i] <= 1'b1;
                    end else begin
                        wr_count[i*CNT_WIDTH +: CNT_WIDTH] <=
                            wr_count[i*CNT_WIDTH +: CNT_WIDTH] + 1'b1;
                    end
                end
            end
        end
    end

    // Pending result words
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANE_NUM; i++) begin
            if (odata_valid[i]) begin
                pend_data[i] <= odata[i*ODATA_WIDTH +: ODATA_WIDTH];
            end
        end
    end

    for (genvar g = 0; g < LANE_NUM; g++) begin : g_chk
        a_no_overwrite: assert property (@(posedge clk) disable iff (!rstn)
            pend_vld[g] && !gnt[g] |-> !odata_valid[g]);
    end

endmodule

//--- source/core_acc.sv
// Partial-sum accumulator
`timescale 1ns/10ps

module core_acc (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic [acc_pkg::ACC_NUM_WIDTH-1:0]       cfg_acc_num,
    input  logic signed [acc_pkg::PSUM_WIDTH-1:0]   psum,
    input  logic                                    psum_valid,
    output logic signed [acc_pkg::ODATA_WIDTH-1:0]  odata,
    output logic                                    odata_valid
);
    import acc_pkg::*;

    logic [ACC_NUM_WIDTH-1:0]      psum_cnt;
    logic                          last_psum;
    logic                          finish;
    logic signed [ODATA_WIDTH-1:0] psum_ext;
    logic signed [ODATA_WIDTH-1:0] acc_reg;

    // ========================================================================
    // Partial-sum counter
    // ========================================================================
    // Zero count never finishes
    assign last_psum = psum_valid && (cfg_acc_num != '0)
                    && (psum_cnt == cfg_acc_num - 1'b1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            psum_cnt <= '0;
            finish   <= 1'b0;
        end else begin
            finish <= last_psum;
            if (last_psum) begin
                psum_cnt <= '0;
            end else if (psum_valid) begin
                psum_cnt <= psum_cnt + 1'b1;
            end
        end
    end

    // ========================================================================
    // Accumulate and output
    // ========================================================================
    assign psum_ext = {{(ODATA_WIDTH-PSUM_WIDTH){psum[PSUM_WIDTH-1]}}, psum};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_reg     <= '0;
            odata_valid <= 1'b0;
        end else begin
            odata_valid <= finish;
            // A psum in the finish cycle opens the next sum
            if (finish) begin
                acc_reg <= psum_valid ? psum_ext : '0;
            end else if (psum_valid) begin
                acc_reg <= acc_reg + psum_ext;
            end
        end
    end

    // Finished total, held until the next finish
    always_ff @(posedge clk) begin
        if (finish) begin
            odata <= acc_reg;
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rstn)
        odata_valid && (cfg_acc_num > 1) |=> !odata_valid);

endmodule

//--- source/mac_dot.sv
// Four-way signed dot product
`timescale 1ns/10ps

module mac_dot (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic [acc_pkg::LANE_VEC_WIDTH-1:0]     act,
    input  logic [acc_pkg::LANE_VEC_WIDTH-1:0]     wgt,
    input  logic                                   in_valid,
    output logic signed [acc_pkg::PSUM_WIDTH-1:0]  psum,
    output logic                                   psum_valid
);
    import acc_pkg::*;

    logic signed [PSUM_WIDTH-1:0] dot_sum;

    // Products summed at full partial-sum width
    always_comb begin
        logic signed [IDATA_WIDTH-1:0]   a_el;
        logic signed [IDATA_WIDTH-1:0]   w_el;
        logic signed [2*IDATA_WIDTH-1:0] prod;
        dot_sum = '0;
        for (int i = 0; i < MAC_MULT_NUM; i++) begin
            a_el    = act[i*IDATA_WIDTH +: IDATA_WIDTH];
            w_el    = wgt[i*IDATA_WIDTH +: IDATA_WIDTH];
            prod    = a_el * w_el;
            // Signed add extends prod
            dot_sum = dot_sum + prod;
        end
    end

    // Valid bit
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= in_valid;
        end
    end

    // Sum captured only for accepted vectors
    always_ff @(posedge clk) begin
        if (in_valid) begin
            psum <= dot_sum;
        end
    end

    a_psum_known: assert property (@(posedge clk) disable iff (!rstn)
        psum_valid |-> !$isunknown(psum));

endmodule

//--- source/acc_pkg.sv
// Accumulation subsystem definitions
package acc_pkg;

    // ========================================================================
    // Datapath widths
    // ========================================================================
    localparam int IDATA_WIDTH    = 8;
    localparam int MAC_MULT_NUM   = 4;
    // One lane's activation or weight vector
    localparam int LANE_VEC_WIDTH = MAC_MULT_NUM * IDATA_WIDTH;
    localparam int PSUM_WIDTH     = 2 * IDATA_WIDTH + $clog2(MAC_MULT_NUM);
    // Five guard bits above the partial sum
    localparam int ODATA_WIDTH    = PSUM_WIDTH + 5;
    localparam int ACC_NUM_WIDTH  = 8;

    // ========================================================================
    // Lanes and result memory
    // ========================================================================
    localparam int LANE_NUM       = 2;
    localparam int RES_DEPTH      = 16;
    localparam int LANE_DEPTH     = RES_DEPTH / LANE_NUM;
    localparam int RES_ADDR_WIDTH = $clog2(RES_DEPTH);
    // Count must reach LANE_DEPTH itself
    localparam int CNT_WIDTH      = $clog2(LANE_DEPTH) + 1;
    // Both lanes plus the APB read port
    localparam int REQ_NUM        = LANE_NUM + 1;
    localparam int REQ_PTR_WIDTH  = $clog2(REQ_NUM);

    // ========================================================================
    // APB register map
    // ========================================================================
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL        = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_ACC_NUM     = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS      = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_RESULT_BASE = 8'h40;

endpackage
